/* Makefile */
TOP     = tb_calc_top
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f src.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/calc_core.sv */
`timescale 1ns/10ps
`default_nettype none

module calc_core
    import calc_pkg::*;
(
    input  wire logic      sys_clk,
    input  wire logic      sys_rst_n,
    input  wire logic      key_valid,
    input  wire key_code_t key_data,
    output disp_data_t     show_data
);

    typedef enum logic [2:0] {
        ENTER_A,
        ENTER_B,
        COMPUTE,
        FORMAT,
        RESULT
    } calc_state_t;

    calc_state_t state;
    operand_t    num_a;
    operand_t    num_b;
    operand_t    result;
    key_code_t   opcode;
    logic        is_digit;
    logic        is_oper;
    logic        is_equal;

    // Double dabble, valid for values up to DISPLAY_MAX
    function automatic disp_data_t bin_to_bcd(input operand_t value);
        disp_data_t bcd;
        integer     i;
        integer     j;
        bcd = '0;
        for (i = 23; i >= 0; i--) begin
            for (j = 0; j < NUM_DIGITS; j++) begin
                if (bcd[4*j +: 4] >= 4'd5) begin
                    bcd[4*j +: 4] = bcd[4*j +: 4] + 4'd3;
                end
            end
            bcd = {bcd[22:0], value[i]};
        end
        return bcd;
    endfunction

    assign is_digit = key_valid && (key_data < KEY_DIGIT_LIMIT);
    assign is_oper  = key_valid && (key_data >= KEY_DIGIT_LIMIT) && (key_data < KEY_EQ_FIRST);
    assign is_equal = key_valid && (key_data >= KEY_EQ_FIRST);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= ENTER_A;
            num_a     <= '0;
            num_b     <= '0;
            result    <= '0;
            opcode    <= '0;
            show_data <= '0;
        end else begin
            case (state)
                ENTER_A: begin
                    if (is_digit) begin
                        show_data <= {show_data[19:0], key_data};  // Shift in from the right
                        num_a     <= num_a * operand_t'(10) + operand_t'(key_data);
                    end else if (is_oper) begin
                        show_data <= '0;
                        num_b     <= '0;
                        opcode    <= key_data;
                        state     <= ENTER_B;
                    end
                end
                ENTER_B: begin
                    if (is_digit) begin
                        show_data <= {show_data[19:0], key_data};
                        num_b     <= num_b * operand_t'(10) + operand_t'(key_data);
                    end else if (is_equal) begin
                        state <= COMPUTE;  // Second operator key is ignored
                    end
                end
                COMPUTE: begin
                    case (opcode)
                        KEY_ADD: result <= num_a + num_b;
                        KEY_SUB: result <= num_a - num_b;  // Wraps high when negative
                        KEY_MUL: result <= num_a * num_b;
                        KEY_DIV: result <= (num_b == '0) ? '1 : num_a / num_b;
                        default: result <= '0;
                    endcase
                    state <= FORMAT;
                end
                FORMAT: begin
                    if (result > DISPLAY_MAX) begin
                        show_data <= DISP_ERROR;
                    end else begin
                        show_data <= bin_to_bcd(result);
                    end
                    state <= RESULT;
                end
                RESULT: begin
                    if (is_digit) begin
                        show_data <= {20'h0, key_data};  // New calculation
                        num_a     <= operand_t'(key_data);
                        num_b     <= '0;
                        state     <= ENTER_A;
                    end else if (is_oper) begin
                        show_data <= '0;
                        num_a     <= result;  // Chain on the previous result
                        num_b     <= '0;
                        opcode    <= key_data;
                        state     <= ENTER_B;
                    end
                end
                default: state <= ENTER_A;
            endcase
        end
    end

    a_state_legal : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        state inside {ENTER_A, ENTER_B, COMPUTE, FORMAT, RESULT}
    ) else $error("calc_core state out of range");

endmodule

`default_nettype wire

/* logic/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    typedef logic [3:0]  key_code_t;    // Row times four plus column
    typedef logic [1:0]  col_idx_t;     // Index of the driven column
    typedef logic [3:0]  row_bits_t;    // Set bit means the row is pressed
    typedef logic [23:0] operand_t;     // Binary operand or result
    typedef logic [23:0] disp_data_t;   // Six nibbles, leftmost digit on top
    typedef logic [7:0]  seg_code_t;    // Active low {dp, g, f, e, d, c, b, a}

    localparam int NUM_ROWS   = 4;
    localparam int NUM_COLS   = 4;
    localparam int NUM_DIGITS = 6;

    // Key layout
    localparam key_code_t KEY_DIGIT_LIMIT = 4'd10;  // Codes below are digits
    localparam key_code_t KEY_ADD         = 4'd10;
    localparam key_code_t KEY_SUB         = 4'd11;
    localparam key_code_t KEY_MUL         = 4'd12;
    localparam key_code_t KEY_DIV         = 4'd13;
    localparam key_code_t KEY_EQ_FIRST    = 4'd14;  // 14 and 15 are equals

    localparam operand_t   DISPLAY_MAX = 24'd999999;  // Largest showable value
    localparam disp_data_t DISP_ERROR  = 24'hFFFFFF;  // Shown as six dashes

endpackage

`default_nettype wire

/* logic/calc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module calc_top
    import calc_pkg::*;
#(
    parameter int SCAN_DIV        = 50000,
    parameter int DEBOUNCE_CYCLES = 20000,
    parameter int REFRESH_DIV     = 10000
) (
    input  wire logic       sys_clk,
    input  wire logic       sys_rst_n,
    input  wire logic [3:0] key_row,   // Active low, pulled up
    output logic [3:0]      key_col,   // Active low
    output logic [5:0]      seg_sel,
    output seg_code_t       seg_code
);

    row_bits_t  row_stable;
    col_idx_t   col_idx;
    logic       key_valid;
    key_code_t  key_data;
    disp_data_t show_data;

    // A column must dwell long enough for a press to settle before it moves on
    if (SCAN_DIV <= DEBOUNCE_CYCLES + 4) begin : g_param_check
        $error("SCAN_DIV must exceed DEBOUNCE_CYCLES + 4");
    end

    keypad_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_keypad_scan (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .row_stable (row_stable),
        .key_col    (key_col),
        .col_idx    (col_idx)
    );

    for (genvar g = 0; g < NUM_ROWS; g++) begin : g_row
        row_debounce #(
            .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) u_row_debounce (
            .sys_clk    (sys_clk),
            .sys_rst_n  (sys_rst_n),
            .row_raw    (~key_row[g]),  // Pressed reads high
            .row_stable (row_stable[g])
        );
    end

    key_encoder u_key_encoder (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .row_stable (row_stable),
        .col_idx    (col_idx),
        .key_valid  (key_valid),
        .key_data   (key_data)
    );

    calc_core u_calc_core (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .key_valid  (key_valid),
        .key_data   (key_data),
        .show_data  (show_data)
    );

    seg_display #(
        .REFRESH_DIV (REFRESH_DIV)
    ) u_seg_display (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .show_data  (show_data),
        .seg_sel    (seg_sel),
        .seg_code   (seg_code)
    );

endmodule

`default_nettype wire

/* logic/key_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module key_encoder
    import calc_pkg::*;
(
    input  wire logic      sys_clk,
    input  wire logic      sys_rst_n,
    input  wire row_bits_t row_stable,
    input  wire col_idx_t  col_idx,
    output logic           key_valid,
    output key_code_t      key_data
);

    logic       any_row;
    logic       any_row_q;
    logic       press_edge;
    logic [1:0] row_sel;

    assign any_row    = |row_stable;
    assign press_edge = any_row && !any_row_q;  // First cycle of a press

    // Lowest pressed row wins
    always_comb begin
        row_sel = 2'd0;
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            if (row_stable[r]) begin
                row_sel = 2'(r);
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            any_row_q <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            any_row_q <= any_row;
            key_valid <= press_edge;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (press_edge) begin
            key_data <= {row_sel, col_idx};  // Row times four plus column
        end
    end

    a_single_pulse : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        key_valid |=> !key_valid
    ) else $error("key_valid high on two consecutive cycles");

endmodule

`default_nettype wire

/* logic/keypad_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module keypad_scan
    import calc_pkg::*;
#(
    parameter int SCAN_DIV = 50000
) (
    input  wire logic          sys_clk,
    input  wire logic          sys_rst_n,
    input  wire row_bits_t     row_stable,
    output logic [NUM_COLS-1:0] key_col,
    output col_idx_t           col_idx
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0] dwell_cnt;
    logic             key_held;

    assign key_held = |row_stable;  // Freeze the scan under a pressed key

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            dwell_cnt <= '0;
            col_idx   <= '0;
        end else if (!key_held) begin
            if (dwell_cnt == CNT_W'(SCAN_DIV - 1)) begin
                dwell_cnt <= '0;
                col_idx   <= col_idx + 2'd1;  // Wraps after the last column
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    // One column pulled low, the others released
    assign key_col = ~(4'b0001 << col_idx);

    // Exactly one column may be driven, otherwise two keys could share a row
    a_one_col_low : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot(~key_col)
    ) else $error("key_col drives more or less than one column");

endmodule

`default_nettype wire

/* logic/row_debounce.sv */
`timescale 1ns/10ps
`default_nettype none

module row_debounce #(
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  wire logic sys_clk,
    input  wire logic sys_rst_n,
    input  wire logic row_raw,
    output logic      row_stable
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic             sync_meta;
    logic             sync_q;
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_meta  <= 1'b0;
            sync_q     <= 1'b0;
            stable_cnt <= '0;
            row_stable <= 1'b0;
        end else begin
            sync_meta <= row_raw;    // First synchronizer stage
            sync_q    <= sync_meta;
            if (sync_q == row_stable) begin
                stable_cnt <= '0;    // Back to the old level, start over
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                row_stable <= sync_q;  // New level held long enough
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/seg_display.sv */
`timescale 1ns/10ps
`default_nettype none

module seg_display
    import calc_pkg::*;
#(
    parameter int REFRESH_DIV = 10000
) (
    input  wire logic       sys_clk,
    input  wire logic       sys_rst_n,
    input  wire disp_data_t show_data,
    output logic [5:0]      seg_sel,
    output seg_code_t       seg_code
);

    localparam int CNT_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

    logic [CNT_W-1:0] refresh_cnt;
    logic [2:0]       digit_idx;  // 0 is the leftmost digit
    logic [3:0]       nibble;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            refresh_cnt <= '0;
            digit_idx   <= '0;
        end else if (refresh_cnt == CNT_W'(REFRESH_DIV - 1)) begin
            refresh_cnt <= '0;
            if (digit_idx == 3'(NUM_DIGITS - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 3'd1;
            end
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    assign seg_sel = ~(6'b000001 << digit_idx);  // Active low digit enable

    // Digit 0 takes the high nibble
    always_comb begin
        case (digit_idx)
            3'd0:    nibble = show_data[23:20];
            3'd1:    nibble = show_data[19:16];
            3'd2:    nibble = show_data[15:12];
            3'd3:    nibble = show_data[11:8];
            3'd4:    nibble = show_data[7:4];
            default: nibble = show_data[3:0];
        endcase
    end

    // Common anode patterns, bit order dp g f e d c b a
    always_comb begin
        case (nibble)
            4'h0:    seg_code = 8'hC0;
            4'h1:    seg_code = 8'hF9;
            4'h2:    seg_code = 8'hA4;
            4'h3:    seg_code = 8'hB0;
            4'h4:    seg_code = 8'h99;
            4'h5:    seg_code = 8'h92;
            4'h6:    seg_code = 8'h82;
            4'h7:    seg_code = 8'hF8;
            4'h8:    seg_code = 8'h80;
            4'h9:    seg_code = 8'h90;
            4'hF:    seg_code = 8'hBF;  // Dash for the error word
            default: seg_code = 8'hFF;  // Blank
        endcase
    end

endmodule

`default_nettype wire

/* sim/tb_calc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_calc_top
    import calc_pkg::*;
();

    localparam int     SCAN_DIV        = 40;
    localparam int     DEBOUNCE_CYCLES = 10;
    localparam int     REFRESH_DIV     = 4;
    localparam int     MAX_KEYS        = 100;  // Upper bound of keys over all tests
    localparam longint WATCHDOG_NS     = 2 * MAX_KEYS * 5 * SCAN_DIV * 100;

    localparam logic [7:0] SEG_PAT [0:9] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
                                            8'h92, 8'h82, 8'hF8, 8'h80, 8'h90};

    logic       sys_clk;
    logic       sys_rst_n;
    logic [3:0] key_row;
    logic [3:0] key_col;
    logic [5:0] seg_sel;
    seg_code_t  seg_code;

    int key_log[$];  // Every key pressed since reset
    int tests_run;
    int tests_failed;

    calc_top #(
        .SCAN_DIV        (SCAN_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .REFRESH_DIV     (REFRESH_DIV)
    ) UUT (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .key_row   (key_row),
        .key_col   (key_col),
        .seg_sel   (seg_sel),
        .seg_code  (seg_code)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    function automatic int char_to_key(input byte c);
        case (c)
            "+":     return int'(KEY_ADD);
            "-":     return int'(KEY_SUB);
            "*":     return int'(KEY_MUL);
            "/":     return int'(KEY_DIV);
            "=":     return 14;
            "#":     return 15;  // Second equals key
            default: return int'(c) - 48;
        endcase
    endfunction

    // Replays the key history with the calculator rules
    function automatic disp_data_t expected_display();
        disp_data_t  disp;
        logic [23:0] a;
        logic [23:0] b;
        logic [23:0] res;
        logic [47:0] prod;
        int          op;
        int          k;
        int          i;
        int          mode;  // 0 first operand, 1 second operand, 2 result shown
        disp = '0;
        a    = '0;
        b    = '0;
        res  = '0;
        op   = 0;
        mode = 0;
        for (i = 0; i < key_log.size(); i++) begin
            k = key_log[i];
            if (k < 10) begin
                if (mode == 2) begin
                    disp = 24'(k);  // Fresh calculation
                    a    = 24'(k);
                    b    = '0;
                    mode = 0;
                end else begin
                    disp = {disp[19:0], 4'(k)};
                    if (mode == 0) a = 24'(a * 10 + k);
                    else b = 24'(b * 10 + k);
                end
            end else if (k < 14) begin
                if (mode != 1) begin
                    if (mode == 2) a = res;  // Chain
                    disp = '0;
                    b    = '0;
                    op   = k;
                    mode = 1;
                end
            end else if (mode == 1) begin
                case (op)
                    10:      res = a + b;
                    11:      res = a - b;
                    12: begin
                        prod = a * b;
                        res  = prod[23:0];
                    end
                    default: res = (b == 0) ? 24'hFFFFFF : a / b;
                endcase
                if (res > 24'd999999) begin
                    disp = 24'hFFFFFF;
                end else begin
                    for (int d = 0; d < 6; d++) begin
                        disp[4*d +: 4] = 4'((res / (10 ** d)) % 10);
                    end
                end
                mode = 2;
            end
        end
        return disp;
    endfunction

    function automatic logic [4:0] seg_to_nibble(input logic [7:0] seg);
        if (seg == 8'hBF) return 5'h1F;  // Dash
        for (int d = 0; d < 10; d++) begin
            if (SEG_PAT[d] == seg) return {1'b1, 4'(d)};
        end
        return 5'h00;
    endfunction

    task automatic press_key(input int code);
        logic [1:0] row;
        logic [1:0] col;
        row = 2'(code / 4);
        col = 2'(code % 4);
        while (key_col[col] == 1'b0) @(negedge sys_clk);  // Catch the column at its start
        while (key_col[col] != 1'b0) @(negedge sys_clk);
        repeat (3 * SCAN_DIV) begin
            key_row = (key_col[col] == 1'b0) ? ~(4'b0001 << row) : 4'hF;
            @(negedge sys_clk);
        end
        key_row = 4'hF;
        repeat (2 * SCAN_DIV) @(negedge sys_clk);
        key_log.push_back(code);
    endtask

    task automatic press_keys(input string seq);
        for (int i = 0; i < seq.len(); i++) begin
            press_key(char_to_key(seq[i]));
        end
    endtask

    // One refresh round of the display, decoded back to nibbles
    task automatic check_display(input string name);
        disp_data_t expected;
        disp_data_t captured;
        logic [4:0] dec;
        logic [5:0] seen;
        logic       scan_ok;
        int         idx;
        int         lows;
        expected = expected_display();
        captured = '0;
        seen     = '0;
        scan_ok  = 1'b1;
        repeat (NUM_DIGITS * REFRESH_DIV) begin
            @(negedge sys_clk);
            idx  = 0;
            lows = 0;
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (!seg_sel[i]) begin
                    idx = i;
                    lows++;
                end
            end
            dec = seg_to_nibble(seg_code);
            if (lows != 1 || !dec[4]) begin
                scan_ok = 1'b0;
            end else begin
                captured[4*(NUM_DIGITS-1-idx) +: 4] = dec[3:0];
                seen[idx] = 1'b1;
            end
        end
        tests_run++;
        if (!scan_ok || seen != 6'h3F) begin
            tests_failed++;
            $display("test %s: digit select or segment pattern not recognized", name);
        end else if (captured != expected) begin
            tests_failed++;
            $display("[ERROR] show_data expected %06h captured %06h", expected, captured);
            $display("test %s: mismatch", name);
        end else begin
            $display("test %s: ok, display %06h", name, captured);
        end
    endtask

    initial begin
        int    a;
        int    b;
        int    tmp;
        byte   op_char;
        string seq;
        void'($urandom(66));
        key_row      = 4'hF;
        sys_rst_n    = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);

        tests_run++;
        if ($countones(~key_col) != 1) begin
            tests_failed++;
            $display("[ERROR] key_col expected one low bit captured %01h", key_col);
        end
        $display("test reset columns: done");
        check_display("reset display");

        // Digits shift in from the right, operator clears
        press_keys("1");
        check_display("shift 1");
        press_keys("2");
        check_display("shift 12");
        press_keys("3");
        check_display("shift 123");
        press_keys("+");
        check_display("operator clears");
        press_keys("45=");
        check_display("123+45");

        for (int round = 0; round < 8; round++) begin
            a = $urandom_range(999, 0);
            b = $urandom_range(999, 0);
            case (round % 4)
                0: op_char = "+";
                1: begin
                    op_char = "-";
                    if (a < b) begin
                        tmp = a;  // Keep the difference non-negative
                        a   = b;
                        b   = tmp;
                    end
                end
                2: op_char = "*";
                default: begin
                    op_char = "/";
                    b       = $urandom_range(999, 1);
                end
            endcase
            seq = $sformatf("%0d%c%0d=", a, op_char, b);
            press_keys(seq);
            check_display({"random ", seq});
        end

        press_keys("9999*999=");
        check_display("product overflow");
        press_keys("5-7=");
        check_display("negative difference");
        press_keys("8/0#");
        check_display("divide by zero");

        press_keys("12+3=");
        check_display("chain start");
        press_keys("*4=");
        check_display("chain on result");
        press_keys("7");
        check_display("digit after result");
        press_keys("+2=");
        check_display("new calculation");

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/calc_pkg.sv
logic/keypad_scan.sv
logic/row_debounce.sv
logic/key_encoder.sv
logic/calc_core.sv
logic/seg_display.sv
logic/calc_top.sv
sim/tb_calc_top.sv
